// ==== list.f ====
hw/kbridge_pkg.sv
hw/chan_fifo.sv
hw/host_regs.sv
hw/kbridge_top.sv
tests/tb_axi_mem.sv
tests/tb_kbridge.sv

// ==== tests/tb_kbridge.sv ====
module tb_kbridge;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int period    = 20;
  localparam int poll_max  = 40;  // status reads before giving up
  localparam int n_strobed = 3;
  localparam int wr_acc    = 10 + poll_max + 2;  // staging, two pushes, poll, pop, read
  localparam int rd_acc    = 10 + poll_max;
  localparam int total_acc = 16 + (wr_acc + 1) + (n_strobed * wr_acc + rd_acc) + 19
                             + (4 * wr_acc + 2);
  localparam int watchdog_ns = (3 * total_acc + 10) * period * 2;  // 3 cycles per access

  logic                   clk;
  logic                   rstn;
  logic                   bp;
  kbridge_pkg::apb_req_t  apb_req;
  kbridge_pkg::apb_rsp_t  apb_rsp;
  kbridge_pkg::axi_aw_t   m_aw;
  kbridge_pkg::axi_w_t    m_w;
  kbridge_pkg::axi_ar_t   m_ar;
  logic                   m_awvalid, m_awready, m_wvalid, m_wready, m_arvalid, m_arready;
  logic [3:0]             m_bid, m_rid;
  kbridge_pkg::axi_resp_e m_bresp, m_rresp;
  logic                   m_bvalid, m_bready, m_rvalid, m_rready, m_rlast;
  logic [127:0]           m_rdata;
  logic [31:0]            lfsr = 32'hc84f_6699;
  logic [127:0]           ref_mem [16];

  kbridge_top #(.fifo_log2_depth(2)) dut0 (.*);

  tb_axi_mem mem0 (
    .clk(clk), .rstn(rstn), .bp(bp),
    .aw(m_aw), .awvalid(m_awvalid), .awready(m_awready),
    .w(m_w), .wvalid(m_wvalid), .wready(m_wready),
    .bid(m_bid), .bresp(m_bresp), .bvalid(m_bvalid), .bready(m_bready),
    .ar(m_ar), .arvalid(m_arvalid), .arready(m_arready),
    .rdata(m_rdata), .rid(m_rid), .rresp(m_rresp), .rlast(m_rlast),
    .rvalid(m_rvalid), .rready(m_rready)
  );

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    fail_now("watchdog expired before the tests finished");
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [255:0] exp, input logic [255:0] act);
    if (exp !== act) begin
      fail_now($sformatf("Mismatch %s: expected %0h actual %0h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [127:0] lfsr_data();
    logic [127:0] v;
    for (int i = 0; i < 4; i++) begin
      v[i*32 +: 32] = lfsr_bits(32);
    end
    return v;
  endfunction

  // expected line after a strobed AXI write
  function automatic logic [127:0] apply_strobes(input logic [127:0] old,
                                                 input logic [127:0] data,
                                                 input logic [15:0] strb);
    logic [127:0] v;
    v = old;
    for (int b = 0; b < 16; b++) begin
      if (strb[b]) begin
        v[b*8 +: 8] = data[b*8 +: 8];
      end
    end
    return v;
  endfunction

  task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);  // access phase, response settled
    if (apb_rsp.pready !== 1'b1) begin
      fail_now("pready was low in an APB access phase");
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    apb_xfer(1'b1, addr, data, rd, err);
    check($sformatf("pslverr on write %0h", addr), 0, err);
  endtask

  task automatic read_reg(input logic [11:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check($sformatf("pslverr on read %0h", addr), 0, err);
  endtask

  task automatic stage_fill(input logic [255:0] val, input int n);
    for (int i = 0; i < n; i++) begin
      write_reg(12'(i * 4), val[i*32 +: 32]);
    end
  endtask

  task automatic poll_status(input logic [11:0] addr);
    logic [31:0] rd;
    int          n;
    rd = '0;
    n  = 0;
    while (rd[0] !== 1'b1) begin
      if (n == poll_max) begin
        fail_now($sformatf("status at %0h never reported an entry", addr));
      end
      read_reg(addr, rd);
      n++;
    end
  endtask

  // aw entry is {size, addr}, w entry is {strb, data}
  task automatic axi_write(input logic [63:0] addr, input logic [127:0] data,
                           input logic [15:0] strb);
    logic [255:0] v;
    v       = '0;
    v[66:0] = {3'd4, addr};
    stage_fill(v, 3);
    write_reg(kbridge_pkg::aw_push, 32'd0);
    v        = '0;
    v[143:0] = {strb, data};
    stage_fill(v, 5);
    write_reg(kbridge_pkg::w_push, 32'd0);
    ref_mem[addr[7:4]] = apply_strobes(ref_mem[addr[7:4]], data, strb);
  endtask

  task automatic pop_b();
    logic [31:0] rd;
    poll_status(kbridge_pkg::b_status);
    write_reg(kbridge_pkg::b_pop, 32'd0);
    read_reg(kbridge_pkg::data0, rd);
    check("b_entry", {26'd0, 4'd1, 2'd0}, rd);  // id 1, okay
  endtask

  task automatic axi_read(input logic [63:0] addr, output logic [127:0] data);
    logic [255:0] v;
    logic [31:0]  rd;
    v       = '0;
    v[66:0] = {3'd4, addr};
    stage_fill(v, 3);
    write_reg(kbridge_pkg::ar_push, 32'd0);
    poll_status(kbridge_pkg::r_status);
    write_reg(kbridge_pkg::r_pop, 32'd0);
    for (int i = 0; i < 4; i++) begin
      read_reg(12'(i * 4), rd);
      data[i*32 +: 32] = rd;
    end
    read_reg(kbridge_pkg::data4, rd);
    check("r_id_resp", {26'd0, 4'd2, 2'd0}, rd);  // id 2, okay
  endtask

  // fixed AXI attributes whenever a request is offered
  always @(negedge clk) begin
    if (m_awvalid === 1'b1) begin
      check("aw_attr", {3'd4, 8'd0, 2'd1, 4'd1, 12'd0}, {m_aw.size, m_aw.len, m_aw.burst,
            m_aw.id, m_aw.cache, m_aw.lock, m_aw.prot, m_aw.qos});
    end
    if (m_wvalid === 1'b1) begin
      check("w_last", 1, m_w.last);
    end
    if (m_arvalid === 1'b1) begin
      check("ar_attr", {3'd4, 8'd0, 2'd1, 4'd2, 12'd0}, {m_ar.size, m_ar.len, m_ar.burst,
            m_ar.id, m_ar.cache, m_ar.lock, m_ar.prot, m_ar.qos});
    end
  end

  initial begin
    logic [255:0] v;
    logic [127:0] wd;
    logic [127:0] got;
    logic [15:0]  strb;
    logic [31:0]  rd;
    logic         err;
    apb_req = '0;
    bp      = 1'b0;
    rstn    = 1'b0;
    for (int i = 0; i < 16; i++) begin
      ref_mem[i] = '0;
    end
    repeat (3) @(posedge clk);
    rstn <= 1'b1;

    v[127:0]   = lfsr_data();
    v[255:128] = lfsr_data();
    stage_fill(v, 8);
    for (int i = 0; i < 8; i++) begin
      read_reg(12'(i * 4), rd);
      check("stage_rw", v[i*32 +: 32], rd);
    end

    wd = lfsr_data();
    axi_write(64'h10, wd, 16'hffff);
    pop_b();
    read_reg(kbridge_pkg::b_status, rd);
    check("b_status_empty", 0, rd);

    repeat (n_strobed) begin
      wd   = lfsr_data();
      strb = lfsr_bits(16);
      axi_write(64'h50, wd, strb);
      pop_b();
    end
    axi_read(64'h50, got);
    check("r_data", ref_mem[5], got);

    v[127:0]   = lfsr_data();
    v[255:128] = lfsr_data();
    stage_fill(v, 8);
    apb_xfer(1'b1, kbridge_pkg::b_pop, 32'd0, rd, err);
    check("pop_empty_err", 1, err);
    apb_xfer(1'b0, 12'h070, 32'd0, rd, err);
    check("unmapped_err", 1, err);
    apb_xfer(1'b0, kbridge_pkg::aw_push, 32'd0, rd, err);
    check("push_read_err", 1, err);
    for (int i = 0; i < 8; i++) begin
      read_reg(12'(i * 4), rd);
      check("stage_kept", v[i*32 +: 32], rd);
    end

    @(posedge clk);
    bp <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      wd   = lfsr_data();
      strb = lfsr_bits(16);
      axi_write(64'h80 + 64'(i * 16), wd, strb);
    end
    apb_xfer(1'b1, kbridge_pkg::aw_push, 32'd0, rd, err);
    check("aw_full_err", 1, err);
    @(posedge clk);
    bp <= 1'b0;
    repeat (4) pop_b();
    read_reg(kbridge_pkg::b_status, rd);
    check("b_count", 0, rd);
    for (int i = 8; i < 12; i++) begin
      check($sformatf("mem_slot_%0d", i), ref_mem[i], mem0.mem[i]);
    end

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== tests/tb_axi_mem.sv ====
module tb_axi_mem (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           bp,  // holds all request readies low
  input  kbridge_pkg::axi_aw_t           aw,
  input  logic                           awvalid,
  output logic                           awready,
  input  kbridge_pkg::axi_w_t            w,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [kbridge_pkg::id_w-1:0]   bid,
  output kbridge_pkg::axi_resp_e         bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  kbridge_pkg::axi_ar_t           ar,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [kbridge_pkg::data_w-1:0] rdata,
  output logic [kbridge_pkg::id_w-1:0]   rid,
  output kbridge_pkg::axi_resp_e         rresp,
  output logic                           rlast,
  output logic                           rvalid,
  input  logic                           rready
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [kbridge_pkg::data_w-1:0] mem [16];  // one line per addr[7:4]
  kbridge_pkg::axi_aw_t           aw_q;
  kbridge_pkg::axi_w_t            w_q;
  logic                           aw_full;
  logic                           w_full;

  assign awready = !bp && !aw_full;
  assign wready  = !bp && !w_full;
  assign arready = !bp && !rvalid;
  assign bresp   = kbridge_pkg::okay;
  assign rresp   = kbridge_pkg::okay;
  assign rlast   = 1'b1;

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      aw_q    <= '0;
      w_q     <= '0;
      aw_full <= 1'b0;
      w_full  <= 1'b0;
      bid     <= '0;
      bvalid  <= 1'b0;
      rdata   <= '0;
      rid     <= '0;
      rvalid  <= 1'b0;
      for (int i = 0; i < 16; i++) begin
        mem[i] <= '0;
      end
    end else begin
      if (awvalid && awready) begin
        aw_q    <= aw;
        aw_full <= 1'b1;
      end
      if (wvalid && wready) begin
        w_q    <= w;
        w_full <= 1'b1;
      end
      if (aw_full && w_full && !bvalid) begin  // both halves in, commit
        for (int b = 0; b < kbridge_pkg::strb_w; b++) begin
          if (w_q.strb[b]) begin
            mem[aw_q.addr[7:4]][b*8 +: 8] <= w_q.data[b*8 +: 8];
          end
        end
        bid     <= aw_q.id;
        bvalid  <= 1'b1;
        aw_full <= 1'b0;
        w_full  <= 1'b0;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
      if (arvalid && arready) begin
        rdata  <= mem[ar.addr[7:4]];
        rid    <= ar.id;
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

endmodule

// ==== hw/kbridge_top.sv ====
module kbridge_top #(
  parameter int fifo_log2_depth = 9
) (
  input  logic                  clk,
  input  logic                  rstn,
  input  kbridge_pkg::apb_req_t apb_req,
  output kbridge_pkg::apb_rsp_t apb_rsp,

  output kbridge_pkg::axi_aw_t m_aw,
  output logic                 m_awvalid,
  input  logic                 m_awready,
  output kbridge_pkg::axi_w_t  m_w,
  output logic                 m_wvalid,
  input  logic                 m_wready,

  input  logic [kbridge_pkg::id_w-1:0] m_bid,
  input  kbridge_pkg::axi_resp_e       m_bresp,
  input  logic                         m_bvalid,
  output logic                         m_bready,

  output kbridge_pkg::axi_ar_t m_ar,
  output logic                 m_arvalid,
  input  logic                 m_arready,

  input  logic [kbridge_pkg::data_w-1:0] m_rdata,
  input  logic [kbridge_pkg::id_w-1:0]   m_rid,
  input  kbridge_pkg::axi_resp_e         m_rresp,
  input  logic                           m_rlast,
  input  logic                           m_rvalid,
  output logic                           m_rready
);

  kbridge_pkg::aw_entry_t aw_wdata, aw_rdata;
  kbridge_pkg::w_entry_t  w_wdata, w_rdata;
  kbridge_pkg::aw_entry_t ar_wdata, ar_rdata;
  kbridge_pkg::b_entry_t  b_wdata, b_rdata;
  kbridge_pkg::r_entry_t  r_wdata, r_rdata;

  logic aw_wvalid, aw_wready, aw_rvalid, aw_rready;
  logic w_wvalid, w_wready, w_rvalid, w_rready;
  logic ar_wvalid, ar_wready, ar_rvalid, ar_rready;
  logic b_rvalid, b_rready;
  logic r_rvalid, r_rready;

  host_regs regs0 (
    .clk       (clk),
    .rstn      (rstn),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .aw_wvalid (aw_wvalid),
    .aw_wdata  (aw_wdata),
    .aw_wready (aw_wready),
    .w_wvalid  (w_wvalid),
    .w_wdata   (w_wdata),
    .w_wready  (w_wready),
    .ar_wvalid (ar_wvalid),
    .ar_wdata  (ar_wdata),
    .ar_wready (ar_wready),
    .b_rvalid  (b_rvalid),
    .b_rdata   (b_rdata),
    .b_rready  (b_rready),
    .r_rvalid  (r_rvalid),
    .r_rdata   (r_rdata),
    .r_rready  (r_rready)
  );

  chan_fifo #(.width($bits(kbridge_pkg::aw_entry_t)), .log2_depth(fifo_log2_depth)) aw_q (
    .clk(clk), .rstn(rstn),
    .wvalid(aw_wvalid), .wdata(aw_wdata), .wready(aw_wready),
    .rvalid(aw_rvalid), .rdata(aw_rdata), .rready(aw_rready)
  );

  chan_fifo #(.width($bits(kbridge_pkg::w_entry_t)), .log2_depth(fifo_log2_depth)) w_q (
    .clk(clk), .rstn(rstn),
    .wvalid(w_wvalid), .wdata(w_wdata), .wready(w_wready),
    .rvalid(w_rvalid), .rdata(w_rdata), .rready(w_rready)
  );

  chan_fifo #(.width($bits(kbridge_pkg::aw_entry_t)), .log2_depth(fifo_log2_depth)) ar_q (
    .clk(clk), .rstn(rstn),
    .wvalid(ar_wvalid), .wdata(ar_wdata), .wready(ar_wready),
    .rvalid(ar_rvalid), .rdata(ar_rdata), .rready(ar_rready)
  );

  chan_fifo #(.width($bits(kbridge_pkg::b_entry_t)), .log2_depth(fifo_log2_depth)) b_q (
    .clk(clk), .rstn(rstn),
    .wvalid(m_bvalid), .wdata(b_wdata), .wready(m_bready),
    .rvalid(b_rvalid), .rdata(b_rdata), .rready(b_rready)
  );

  chan_fifo #(.width($bits(kbridge_pkg::r_entry_t)), .log2_depth(fifo_log2_depth)) r_q (
    .clk(clk), .rstn(rstn),
    .wvalid(m_rvalid), .wdata(r_wdata), .wready(m_rready),
    .rvalid(r_rvalid), .rdata(r_rdata), .rready(r_rready)
  );

  // aw: single beat incr, everything else fixed at zero
  assign m_aw      = '{addr: aw_rdata.addr, size: aw_rdata.size, len: 8'd0,
                       burst: kbridge_pkg::incr, id: kbridge_pkg::aw_id,
                       cache: 4'd0, lock: 1'b0, prot: 3'd0, qos: 4'd0};
  assign m_awvalid = aw_rvalid;
  assign aw_rready = m_awready;

  assign m_w      = '{data: w_rdata.data, strb: w_rdata.strb, last: 1'b1};
  assign m_wvalid = w_rvalid;
  assign w_rready = m_wready;

  assign m_ar      = '{addr: ar_rdata.addr, size: ar_rdata.size, len: 8'd0,
                       burst: kbridge_pkg::incr, id: kbridge_pkg::ar_id,
                       cache: 4'd0, lock: 1'b0, prot: 3'd0, qos: 4'd0};
  assign m_arvalid = ar_rvalid;
  assign ar_rready = m_arready;

  // responses queue as they arrive
  assign b_wdata = '{id: m_bid, resp: m_bresp};
  assign r_wdata = '{id: m_rid, resp: m_rresp, data: m_rdata};

  // every read is one beat, so the slave must flag it last
  single_beat_r: assert property (
    @(posedge clk) disable iff (!rstn)
    m_rvalid |-> m_rlast
  );

endmodule

// ==== hw/host_regs.sv ====
module host_regs (
  input  logic                  clk,
  input  logic                  rstn,
  input  kbridge_pkg::apb_req_t apb_req,
  output kbridge_pkg::apb_rsp_t apb_rsp,

  output logic                   aw_wvalid,
  output kbridge_pkg::aw_entry_t aw_wdata,
  input  logic                   aw_wready,

  output logic                  w_wvalid,
  output kbridge_pkg::w_entry_t w_wdata,
  input  logic                  w_wready,

  output logic                   ar_wvalid,
  output kbridge_pkg::aw_entry_t ar_wdata,
  input  logic                   ar_wready,

  input  logic                  b_rvalid,
  input  kbridge_pkg::b_entry_t b_rdata,
  output logic                  b_rready,

  input  logic                  r_rvalid,
  input  kbridge_pkg::r_entry_t r_rdata,
  output logic                  r_rready
);

  localparam int sel_w = $clog2(kbridge_pkg::stage_words);

  kbridge_pkg::reg_off_e          off;
  kbridge_pkg::stage_t            stage;
  logic [sel_w-1:0]               word_sel;
  logic [kbridge_pkg::word_w-1:0] rdata;
  logic                           access;
  logic                           err;
  logic                           wr_en;

  assign access   = apb_req.psel & apb_req.penable;
  assign off      = kbridge_pkg::reg_off_e'(apb_req.paddr);
  assign word_sel = apb_req.paddr[2 +: sel_w];

  // decode, error decision and read mux
  always_comb begin
    err   = 1'b0;
    rdata = '0;
    case (off)
      kbridge_pkg::data0, kbridge_pkg::data1,
      kbridge_pkg::data2, kbridge_pkg::data3,
      kbridge_pkg::data4, kbridge_pkg::data5,
      kbridge_pkg::data6, kbridge_pkg::data7: begin
        rdata = stage[word_sel*kbridge_pkg::word_w +: kbridge_pkg::word_w];
      end
      kbridge_pkg::aw_push: begin
        err = !apb_req.pwrite || !aw_wready;  // write only, queue must have room
      end
      kbridge_pkg::w_push: begin
        err = !apb_req.pwrite || !w_wready;
      end
      kbridge_pkg::ar_push: begin
        err = !apb_req.pwrite || !ar_wready;
      end
      kbridge_pkg::b_status: begin
        err   = apb_req.pwrite;  // read only
        rdata = {{(kbridge_pkg::word_w - 1){1'b0}}, b_rvalid};
      end
      kbridge_pkg::b_pop: begin
        err = !apb_req.pwrite || !b_rvalid;  // nothing to pop
      end
      kbridge_pkg::r_status: begin
        err   = apb_req.pwrite;
        rdata = {{(kbridge_pkg::word_w - 1){1'b0}}, r_rvalid};
      end
      kbridge_pkg::r_pop: begin
        err = !apb_req.pwrite || !r_rvalid;
      end
      default: begin
        err = 1'b1;  // unmapped
      end
    endcase
  end

  assign wr_en = access & apb_req.pwrite & !err;

  assign apb_rsp.prdata  = rdata;
  assign apb_rsp.pready  = access;  // no wait states
  assign apb_rsp.pslverr = access & err;

  // pops take the head entry in the access cycle itself
  assign b_rready = wr_en & (off == kbridge_pkg::b_pop);
  assign r_rready = wr_en & (off == kbridge_pkg::r_pop);

  // push payloads come straight off the low staging bits
  assign aw_wdata = kbridge_pkg::aw_entry_t'(stage[$bits(kbridge_pkg::aw_entry_t)-1:0]);
  assign w_wdata  = kbridge_pkg::w_entry_t'(stage[$bits(kbridge_pkg::w_entry_t)-1:0]);
  assign ar_wdata = kbridge_pkg::aw_entry_t'(stage[$bits(kbridge_pkg::aw_entry_t)-1:0]);

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      aw_wvalid <= 1'b0;
      w_wvalid  <= 1'b0;
      ar_wvalid <= 1'b0;
      stage     <= '0;
    end else begin
      aw_wvalid <= wr_en & (off == kbridge_pkg::aw_push);
      w_wvalid  <= wr_en & (off == kbridge_pkg::w_push);
      ar_wvalid <= wr_en & (off == kbridge_pkg::ar_push);
      if (wr_en) begin
        case (off)
          kbridge_pkg::data0, kbridge_pkg::data1,
          kbridge_pkg::data2, kbridge_pkg::data3,
          kbridge_pkg::data4, kbridge_pkg::data5,
          kbridge_pkg::data6, kbridge_pkg::data7: begin
            stage[word_sel*kbridge_pkg::word_w +: kbridge_pkg::word_w] <= apb_req.pwdata;
          end
          kbridge_pkg::b_pop: begin
            stage <= kbridge_pkg::stage_t'(b_rdata);  // zero extended
          end
          kbridge_pkg::r_pop: begin
            stage <= kbridge_pkg::stage_t'(r_rdata);
          end
          default: begin
            stage <= stage;  // pushes leave staging as is
          end
        endcase
      end
    end
  end

  // apb setup phase keeps a push strobe and a pop apart
  one_strobe: assert property (
    @(posedge clk) disable iff (!rstn)
    $onehot0({aw_wvalid, w_wvalid, ar_wvalid, b_rready, r_rready})
  );

endmodule

// ==== hw/chan_fifo.sv ====
module chan_fifo #(
  parameter int width      = 8,
  parameter int log2_depth = 4
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             wvalid,
  input  logic [width-1:0] wdata,
  output logic             wready,
  output logic             rvalid,
  output logic [width-1:0] rdata,
  input  logic             rready
);

  localparam int depth = 1 << log2_depth;

  logic [width-1:0]      mem [depth];
  logic [log2_depth-1:0] wptr;
  logic [log2_depth-1:0] rptr;
  logic [log2_depth:0]   count;  // one extra bit to tell full from empty
  logic                  push;
  logic                  pop;

  assign wready = (count != (log2_depth + 1)'(depth));
  assign rvalid = (count != '0);
  assign rdata  = mem[rptr];  // show-ahead, head entry always visible

  assign push = wvalid & wready;
  assign pop  = rvalid & rready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wptr] <= wdata;
    end
  end

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      wptr  <= '0;
      rptr  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wptr <= wptr + 1'b1;  // wraps at depth
      end
      if (pop) begin
        rptr <= rptr + 1'b1;
      end
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // idle or simultaneous push and pop
        end
      endcase
    end
  end

  // occupancy never runs past the buffer
  count_bound: assert property (
    @(posedge clk) disable iff (!rstn)
    count <= (log2_depth + 1)'(depth)
  );

  // a stalled head entry must not move under the consumer
  hold_stable: assert property (
    @(posedge clk) disable iff (!rstn)
    rvalid && !rready |=> $stable(rdata)
  );

endmodule

// ==== hw/kbridge_pkg.sv ====
package kbridge_pkg;

  localparam int addr_w      = 64;
  localparam int data_w      = 128;
  localparam int strb_w      = data_w / 8;
  localparam int id_w        = 4;
  localparam int apb_addr_w  = 12;
  localparam int word_w      = 32;  // apb data and staging word
  localparam int stage_words = 8;

  localparam logic [id_w-1:0] aw_id = 4'd1;
  localparam logic [id_w-1:0] ar_id = 4'd2;

  // host register map, byte offsets
  typedef enum logic [apb_addr_w-1:0] {
    data0    = 12'h000,
    data1    = 12'h004,
    data2    = 12'h008,
    data3    = 12'h00c,
    data4    = 12'h010,
    data5    = 12'h014,
    data6    = 12'h018,
    data7    = 12'h01c,
    aw_push  = 12'h020,
    w_push   = 12'h030,
    ar_push  = 12'h040,
    b_status = 12'h050,
    b_pop    = 12'h054,
    r_status = 12'h060,
    r_pop    = 12'h064
  } reg_off_e;

  typedef enum logic [1:0] {
    fixed = 2'd0,
    incr  = 2'd1,
    wrap  = 2'd2
  } axi_burst_e;

  typedef enum logic [1:0] {
    okay   = 2'd0,
    exokay = 2'd1,
    slverr = 2'd2,
    decerr = 2'd3
  } axi_resp_e;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_addr_w-1:0] paddr;
    logic [word_w-1:0]     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [word_w-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [2:0]        size;
    logic [addr_w-1:0] addr;
  } aw_entry_t;

  typedef struct packed {
    logic [strb_w-1:0] strb;
    logic [data_w-1:0] data;
  } w_entry_t;

  typedef struct packed {
    logic [id_w-1:0] id;
    axi_resp_e       resp;
  } b_entry_t;

  typedef struct packed {
    logic [id_w-1:0]   id;
    axi_resp_e         resp;
    logic [data_w-1:0] data;
  } r_entry_t;

  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [2:0]        size;
    logic [7:0]        len;
    axi_burst_e        burst;
    logic [id_w-1:0]   id;
    logic [3:0]        cache;
    logic              lock;
    logic [2:0]        prot;
    logic [3:0]        qos;
  } axi_aw_t;

  typedef axi_aw_t axi_ar_t;  // same request layout

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
  } axi_w_t;

  typedef logic [stage_words*word_w-1:0] stage_t;

endpackage
